// File: source/cpu_pkg.sv
package cpu_pkg;

  localparam int WORD_W = 16;  // data and instruction word width
  localparam int OP_W   = 8;   // opcode field, upper bits of the first word

  // the lower WORD_W-OP_W bits of the first word hold the register number

  typedef enum logic [OP_W-1:0] {
    op_jmp       = 8'd1,   // pc <= operand
    op_ram2reg   = 8'd2,   // reg <= ram[operand]
    op_reg2ram   = 8'd3,   // ram[operand] <= reg
    op_num2reg   = 8'd4,   // reg <= operand
    op_reg_plus  = 8'd5,   // reg <= reg + operand
    op_reg_minus = 8'd6,   // reg <= reg - operand
    op_exit      = 8'd17   // retire, then stop the core
  } opcode_e;

  // exec_core sequencing
  typedef enum logic [2:0] {
    st_idle,           // program load, wait for start
    st_fetch_op,       // first word: opcode and register
    st_fetch_operand,  // second word: address or immediate
    st_decode,
    st_mem_read,       // ram2reg data access
    st_mem_write,      // reg2ram data access
    st_retire,         // hold the retire stream until accepted
    st_halted          // exit or fault, left only by reset
  } core_state_e;

  // page_walker sequencing
  typedef enum logic [1:0] {
    wk_wait,    // ready for a request
    wk_search,  // follow the chain one page per cycle
    wk_alloc,   // scan for a free physical page
    wk_found    // answer on the done signals
  } walk_state_e;

endpackage

// File: source/word_ram.sv
`timescale 1ns/1ps

module word_ram
  import cpu_pkg::*;
#(
  parameter  int PAGE_WORDS = 64,
  parameter  int NUM_PAGES  = 16,
  localparam int RAM_WORDS  = PAGE_WORDS * NUM_PAGES,
  localparam int AW         = $clog2(RAM_WORDS)
) (
  input  logic              clka,
  input  logic              wr_en,
  input  logic [AW-1:0]     wr_addr,
  input  logic [WORD_W-1:0] wr_data,
  input  logic              rd_en,
  input  logic [AW-1:0]     rd_addr,
  output logic [WORD_W-1:0] rd_data
);

  logic [WORD_W-1:0] mem [RAM_WORDS];

  always_ff @(posedge clka) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // a read and a write to the same word in one cycle return the old word
  always_ff @(posedge clka) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // valid the cycle after rd_en
    end
  end

endmodule

// File: source/page_walker.sv
`timescale 1ns/1ps

module page_walker
  import cpu_pkg::*;
#(
  parameter  int PAGE_WORDS = 64,
  parameter  int NUM_PAGES  = 16,
  localparam int RAM_WORDS  = PAGE_WORDS * NUM_PAGES,
  localparam int AW         = $clog2(RAM_WORDS),
  localparam int PW         = (NUM_PAGES > 1) ? $clog2(NUM_PAGES) : 1
) (
  input  logic              clka,
  input  logic              rst_n,
  input  logic              xlate_valid,
  input  logic [WORD_W-1:0] xlate_addr,
  output logic              xlate_ready,
  output logic              done_valid,
  output logic [AW-1:0]     done_phys,
  output logic              done_fault
);

  localparam logic [PW-1:0] LAST_PAGE = PW'(NUM_PAGES - 1);

  walk_state_e state;

  // page table, one entry per physical page
  logic [PW-1:0]     chain_next [NUM_PAGES];  // next page of the chain, self at the end
  logic [WORD_W-1:0] log_page   [NUM_PAGES];  // logical page held by this physical page
  logic [NUM_PAGES-1:0] used;

  logic [WORD_W-1:0] last_lpage;  // last translation
  logic [PW-1:0]     last_ppage;
  logic [PW-1:0]     scan_ptr;    // lowest page that may still be free
  logic [PW-1:0]     cur_page;    // chain position, tail while allocating
  logic              fault_q;

  logic [WORD_W-1:0] req_lpage;
  logic [AW-1:0]     req_off;
  logic [WORD_W-1:0] in_lpage;
  logic [AW-1:0]     in_off;

  assign in_lpage = WORD_W'(xlate_addr / PAGE_WORDS);
  assign in_off   = AW'(xlate_addr % PAGE_WORDS);

  assign xlate_ready = (state == wk_wait);
  assign done_valid  = (state == wk_found);
  assign done_fault  = fault_q;
  assign done_phys   = AW'(cur_page * PAGE_WORDS) + req_off;

  always_ff @(posedge clka) begin
    if (xlate_valid && state == wk_wait) begin
      req_lpage <= in_lpage;
      req_off   <= in_off;
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state      <= wk_wait;
      last_lpage <= '0;
      last_ppage <= '0;
      scan_ptr   <= PW'(1);
      cur_page   <= '0;
      fault_q    <= 1'b0;
      used       <= '0;
      for (int i = 0; i < NUM_PAGES; i++) begin
        chain_next[i] <= '0;
        log_page[i]   <= '0;
      end
      used[0] <= 1'b1;  // page 0 holds logical page 0, start and end of the chain
    end else begin
      case (state)
        wk_wait: begin
          if (xlate_valid) begin
            fault_q <= 1'b0;
            if (in_lpage == last_lpage) begin
              cur_page <= last_ppage;
              state    <= wk_found;
            end else begin
              cur_page <= '0;  // chain always starts at page 0
              state    <= wk_search;
            end
          end
        end
        wk_search: begin
          if (log_page[cur_page] == req_lpage) begin
            last_lpage <= req_lpage;
            last_ppage <= cur_page;
            state      <= wk_found;
          end else if (chain_next[cur_page] == cur_page) begin
            state <= wk_alloc;  // cur_page is the tail
          end else begin
            cur_page <= chain_next[cur_page];
          end
        end
        wk_alloc: begin
          if (!used[scan_ptr]) begin
            chain_next[cur_page] <= scan_ptr;  // link behind the old tail
            chain_next[scan_ptr] <= scan_ptr;  // new tail
            log_page[scan_ptr]   <= req_lpage;
            used[scan_ptr]       <= 1'b1;
            cur_page             <= scan_ptr;
            last_lpage           <= req_lpage;
            last_ppage           <= scan_ptr;
            if (scan_ptr != LAST_PAGE) begin
              scan_ptr <= scan_ptr + PW'(1);
            end
            state <= wk_found;
          end else if (scan_ptr == LAST_PAGE) begin
            fault_q <= 1'b1;  // memory full
            state   <= wk_found;
          end else begin
            scan_ptr <= scan_ptr + PW'(1);
          end
        end
        default: begin
          state <= wk_wait;  // done pulse lasts one cycle
        end
      endcase
    end
  end

  a_phys_in_range: assert property (@(posedge clka) disable iff (!rst_n)
    done_valid && !done_fault |-> done_phys < RAM_WORDS)
    else $error("translated address outside the RAM");

endmodule

// File: source/exec_core.sv
`timescale 1ns/1ps

module exec_core
  import cpu_pkg::*;
#(
  parameter  int PAGE_WORDS = 64,
  parameter  int NUM_PAGES  = 16,
  parameter  int NUM_REGS   = 8,
  localparam int AW         = $clog2(PAGE_WORDS * NUM_PAGES),
  localparam int RW         = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1,
  localparam int RF_W       = WORD_W - OP_W
) (
  input  logic              clka,
  input  logic              rst_n,
  input  logic              start,
  input  logic              load_valid,
  input  logic [AW-1:0]     load_addr,
  input  logic [WORD_W-1:0] load_data,
  input  logic              retire_ready,
  input  logic              xlate_ready,
  input  logic              done_valid,
  input  logic [AW-1:0]     done_phys,
  input  logic              done_fault,
  input  logic [WORD_W-1:0] rd_data,
  output logic              load_ready,
  output logic              retire_valid,
  output opcode_e           retire_op,
  output logic [RF_W-1:0]   retire_reg,
  output logic [WORD_W-1:0] retire_value,
  output logic [AW-1:0]     retire_phys_addr,
  output logic              halted,
  output logic              fault,
  output logic              xlate_valid,
  output logic [WORD_W-1:0] xlate_addr,
  output logic              wr_en,
  output logic [AW-1:0]     wr_addr,
  output logic [WORD_W-1:0] wr_data,
  output logic              rd_en,
  output logic [AW-1:0]     rd_addr
);

  // steps of one translated RAM access
  typedef enum logic [1:0] {
    ph_req,    // translation request on the walker handshake
    ph_xlate,  // wait for done_valid, RAM access on that cycle
    ph_data    // rd_data valid
  } phase_e;

  core_state_e state;
  phase_e      phase;

  logic [WORD_W-1:0] pc;
  logic [WORD_W-1:0] regs [NUM_REGS];

  opcode_e           inst_op;
  logic [RF_W-1:0]   inst_reg;
  logic [WORD_W-1:0] operand;
  logic [WORD_W-1:0] result;  // retire value, also the reg2ram store word
  logic [AW-1:0]     phys_q;

  logic [RW-1:0]     reg_idx;
  logic [WORD_W-1:0] alu_value;
  logic              access_state;
  logic              data_state;
  logic              xlate_ok;

  assign reg_idx      = RW'(inst_reg % NUM_REGS);
  assign access_state = (state == st_fetch_op) || (state == st_fetch_operand) ||
                        (state == st_mem_read) || (state == st_mem_write);
  assign data_state   = (state == st_mem_read) || (state == st_mem_write);
  assign xlate_ok     = access_state && (phase == ph_xlate) && done_valid && !done_fault;

  always_comb begin
    case (inst_op)
      op_jmp, op_num2reg: alu_value = operand;
      op_reg_plus:        alu_value = regs[reg_idx] + operand;  // wraps at 16 bits
      op_reg_minus:       alu_value = regs[reg_idx] - operand;
      op_reg2ram:         alu_value = regs[reg_idx];
      default:            alu_value = '0;
    endcase
  end

  assign load_ready  = (state == st_idle);
  assign halted      = (state == st_halted);
  assign xlate_valid = access_state && (phase == ph_req);
  assign xlate_addr  = data_state ? operand : pc;

  // the RAM is addressed straight from the walker answer
  assign rd_en   = xlate_ok && (state != st_mem_write);
  assign rd_addr = done_phys;
  assign wr_en   = (state == st_idle && load_valid) || (xlate_ok && state == st_mem_write);
  assign wr_addr = (state == st_idle) ? load_addr : done_phys;
  assign wr_data = (state == st_idle) ? load_data : result;

  assign retire_valid     = (state == st_retire);
  assign retire_op        = inst_op;
  assign retire_reg       = inst_reg;
  assign retire_value     = result;
  assign retire_phys_addr = phys_q;

  always_ff @(posedge clka) begin
    if (phase == ph_data && state == st_fetch_op) begin
      inst_op  <= opcode_e'(rd_data[WORD_W-1:RF_W]);
      inst_reg <= rd_data[RF_W-1:0];
    end
    if (phase == ph_data && state == st_fetch_operand) begin
      operand <= rd_data;
    end
    if (state == st_decode) begin
      result <= alu_value;
      phys_q <= '0;  // only memory ops report an address
    end
    if (phase == ph_data && state == st_mem_read) begin
      result <= rd_data;
    end
    if (xlate_ok && data_state) begin
      phys_q <= done_phys;
    end
  end

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      phase <= ph_req;
      pc    <= '0;
      fault <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            pc    <= '0;  // program starts at logical 0
            phase <= ph_req;
            state <= st_fetch_op;
          end
        end
        st_fetch_op, st_fetch_operand, st_mem_read, st_mem_write: begin
          case (phase)
            ph_req: begin
              if (xlate_ready) begin
                phase <= ph_xlate;
              end
            end
            ph_xlate: begin
              if (done_valid) begin
                if (done_fault) begin
                  fault <= 1'b1;  // faulting instruction is dropped
                  state <= st_halted;
                end else if (state == st_mem_write) begin
                  phase <= ph_req;
                  state <= st_retire;  // word written on this edge
                end else begin
                  phase <= ph_data;
                end
              end
            end
            ph_data: begin
              phase <= ph_req;
              case (state)
                st_fetch_op: begin
                  pc    <= pc + 1'b1;
                  state <= st_fetch_operand;
                end
                st_fetch_operand: begin
                  pc    <= pc + 1'b1;
                  state <= st_decode;
                end
                default: begin
                  regs[reg_idx] <= rd_data;  // ram2reg
                  state         <= st_retire;
                end
              endcase
            end
            default: phase <= ph_req;
          endcase
        end
        st_decode: begin
          phase <= ph_req;
          case (inst_op)
            op_ram2reg: state <= st_mem_read;
            op_reg2ram: state <= st_mem_write;
            op_jmp: begin
              pc    <= operand;
              state <= st_retire;
            end
            op_num2reg, op_reg_plus, op_reg_minus: begin
              regs[reg_idx] <= alu_value;
              state         <= st_retire;
            end
            default: state <= st_retire;  // exit and unknown opcodes
          endcase
        end
        st_retire: begin
          if (retire_ready) begin
            state <= (inst_op == op_exit) ? st_halted : st_fetch_op;
          end
        end
        default: state <= st_halted;  // stays until reset
      endcase
    end
  end

  a_retire_hold: assert property (@(posedge clka) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_op) &&
      $stable(retire_reg) && $stable(retire_value) && $stable(retire_phys_addr))
    else $error("retire fields changed while stalled");

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter  int PAGE_WORDS = 64,
  parameter  int NUM_PAGES  = 16,
  parameter  int NUM_REGS   = 8,
  localparam int AW         = $clog2(PAGE_WORDS * NUM_PAGES),
  localparam int RF_W       = WORD_W - OP_W
) (
  input  logic              clka,
  input  logic              rst_n,
  input  logic              start,
  input  logic              load_valid,
  input  logic [AW-1:0]     load_addr,
  input  logic [WORD_W-1:0] load_data,
  input  logic              retire_ready,
  output logic              load_ready,
  output logic              retire_valid,
  output opcode_e           retire_op,
  output logic [RF_W-1:0]   retire_reg,
  output logic [WORD_W-1:0] retire_value,
  output logic [AW-1:0]     retire_phys_addr,
  output logic              halted,
  output logic              fault
);

  // translation handshake
  logic              xlate_valid;
  logic              xlate_ready;
  logic [WORD_W-1:0] xlate_addr;
  logic              done_valid;
  logic [AW-1:0]     done_phys;
  logic              done_fault;

  // RAM ports
  logic              wr_en;
  logic [AW-1:0]     wr_addr;
  logic [WORD_W-1:0] wr_data;
  logic              rd_en;
  logic [AW-1:0]     rd_addr;
  logic [WORD_W-1:0] rd_data;

  exec_core #(
    .PAGE_WORDS(PAGE_WORDS),
    .NUM_PAGES (NUM_PAGES),
    .NUM_REGS  (NUM_REGS)
  ) exec_core_inst (
    .clka            (clka),
    .rst_n           (rst_n),
    .start           (start),
    .load_valid      (load_valid),
    .load_addr       (load_addr),
    .load_data       (load_data),
    .retire_ready    (retire_ready),
    .xlate_ready     (xlate_ready),
    .done_valid      (done_valid),
    .done_phys       (done_phys),
    .done_fault      (done_fault),
    .rd_data         (rd_data),
    .load_ready      (load_ready),
    .retire_valid    (retire_valid),
    .retire_op       (retire_op),
    .retire_reg      (retire_reg),
    .retire_value    (retire_value),
    .retire_phys_addr(retire_phys_addr),
    .halted          (halted),
    .fault           (fault),
    .xlate_valid     (xlate_valid),
    .xlate_addr      (xlate_addr),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr)
  );

  page_walker #(
    .PAGE_WORDS(PAGE_WORDS),
    .NUM_PAGES (NUM_PAGES)
  ) page_walker_inst (
    .clka       (clka),
    .rst_n      (rst_n),
    .xlate_valid(xlate_valid),
    .xlate_addr (xlate_addr),
    .xlate_ready(xlate_ready),
    .done_valid (done_valid),
    .done_phys  (done_phys),
    .done_fault (done_fault)
  );

  word_ram #(
    .PAGE_WORDS(PAGE_WORDS),
    .NUM_PAGES (NUM_PAGES)
  ) word_ram_inst (
    .clka   (clka),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

endmodule

// File: tests/cpu_ref_model.sv
package cpu_ref_model;
  import cpu_pkg::*;

  localparam int PAGE_WORDS = 64;  // default cpu_top geometry
  localparam int NUM_PAGES  = 16;

  typedef struct {
    opcode_e     op;
    logic [7:0]  rnum;
    logic [15:0] value;
    logic [9:0]  phys;
    bit          has_value;  // exit and unknown opcodes carry no result
  } retire_t;

  logic [15:0] load_addr_q [$];  // program words, then preloaded data words
  logic [15:0] load_data_q [$];
  int          prog_words;
  retire_t     exp_q [$];
  bit          exp_fault;

  logic [15:0] ref_mem [PAGE_WORDS*NUM_PAGES];  // kept across resets like the RAM
  int          page_map [1024];                 // logical to physical page, -1 if untouched
  int          next_free;
  logic [15:0] ref_regs [8];

  function automatic void new_program();
    load_addr_q.delete();
    load_data_q.delete();
    prog_words = 0;
  endfunction

  function automatic void add_word(int addr, logic [15:0] data);
    load_addr_q.push_back(16'(addr));
    load_data_q.push_back(data);
  endfunction

  function automatic void add_inst(opcode_e op, int rnum, logic [15:0] arg);
    add_word(prog_words, {op, 8'(rnum)});
    add_word(prog_words + 1, arg);
    prog_words += 2;
  endfunction

  function automatic void reset_model();
    foreach (page_map[i]) page_map[i] = -1;
    page_map[0] = 0;  // logical page 0 lives in physical page 0
    next_free   = 1;
    foreach (ref_regs[i]) ref_regs[i] = '0;
    exp_q.delete();
    exp_fault = 1'b0;
  endfunction

  // pages are handed out lowest first, in order of first touch
  function automatic bit translate(logic [15:0] la, output logic [9:0] pa);
    int lp;
    lp = la / PAGE_WORDS;
    if (page_map[lp] < 0) begin
      if (next_free >= NUM_PAGES) return 1'b0;  // memory full
      page_map[lp] = next_free;
      next_free++;
    end
    pa = 10'(page_map[lp] * PAGE_WORDS + la % PAGE_WORDS);
    return 1'b1;
  endfunction

  function automatic bit read_logical(logic [15:0] la, output logic [15:0] word);
    logic [9:0] pa;
    read_logical = translate(la, pa);
    if (read_logical) word = ref_mem[pa];
  endfunction

  function automatic void run_model(int max_inst);
    logic [15:0] pc;
    logic [15:0] w0;
    logic [15:0] w1;
    logic [2:0]  r;
    retire_t     rec;
    foreach (load_addr_q[i]) ref_mem[load_addr_q[i]] = load_data_q[i];
    pc = '0;
    repeat (max_inst) begin
      if (!read_logical(pc, w0) || !read_logical(pc + 16'd1, w1)) begin
        exp_fault = 1'b1;
        return;
      end
      pc            = pc + 16'd2;
      rec.op        = opcode_e'(w0[15:8]);
      rec.rnum      = w0[7:0];
      rec.phys      = '0;
      rec.has_value = 1'b1;
      r             = w0[2:0];  // eight registers
      case (rec.op)
        op_jmp:       pc = w1;
        op_num2reg:   ref_regs[r] = w1;
        op_reg_plus:  ref_regs[r] = ref_regs[r] + w1;
        op_reg_minus: ref_regs[r] = ref_regs[r] - w1;
        op_ram2reg, op_reg2ram: begin
          if (!translate(w1, rec.phys)) begin
            exp_fault = 1'b1;  // faulting instruction never retires
            return;
          end
          if (rec.op == op_ram2reg) ref_regs[r] = ref_mem[rec.phys];
          else ref_mem[rec.phys] = ref_regs[r];
        end
        default: rec.has_value = 1'b0;
      endcase
      rec.value = (rec.op == op_jmp) ? pc : ref_regs[r];
      exp_q.push_back(rec);
      if (rec.op == op_exit) return;
    end
  endfunction

endpackage

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
  import cpu_pkg::*;
  import cpu_ref_model::*;
();

  logic              clka;
  logic              rst_n;
  logic              start;
  logic              load_valid;
  logic [9:0]        load_addr;
  logic [WORD_W-1:0] load_data;
  logic              retire_ready;
  logic              load_ready;
  logic              retire_valid;
  opcode_e           retire_op;
  logic [7:0]        retire_reg;
  logic [WORD_W-1:0] retire_value;
  logic [9:0]        retire_phys_addr;
  logic              halted;
  logic              fault;

  integer  seed;
  int      seen;       // retires checked so far
  int      total_exp;  // retires predicted over all runs
  retire_t want;

  cpu_top cpu_top_inst (.*);

  initial begin
    clka = 1'b0;
    forever #50 clka = ~clka;
  end

  // random low periods on retire_ready
  always @(posedge clka) begin
    #5 retire_ready = ($random(seed) & 3) != 0;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [15:0] want_v,
                             input logic [15:0] got);
    assert (got === want_v)
      else stop_with_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                     name, want_v, got));
  endtask

  always @(posedge clka) begin
    if (rst_n && retire_valid && retire_ready) begin
      if (exp_q.size() == 0) begin
        stop_with_error("a retire arrived that the model did not predict");
      end else begin
        want = exp_q.pop_front();
        check_field("retire_op", 16'(want.op), 16'(retire_op));
        check_field("retire_reg", 16'(want.rnum), 16'(retire_reg));
        if (want.has_value) check_field("retire_value", want.value, retire_value);
        check_field("retire_phys_addr", 16'(want.phys), 16'(retire_phys_addr));
        seen++;
      end
    end
  end

  a_retire_stall: assert property (@(posedge clka) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_op) &&
      $stable(retire_reg) && $stable(retire_value) && $stable(retire_phys_addr))
    else stop_with_error("retire fields changed while retire_ready was low");

  a_quiet_halt: assert property (@(posedge clka) disable iff (!rst_n) halted |-> !retire_valid)
    else stop_with_error("retire_valid was high while the core was halted");

  a_fault_halts: assert property (@(posedge clka) disable iff (!rst_n) fault |-> halted)
    else stop_with_error("fault was high but the core did not halt");

  // the load port only opens while the core is idle
  a_load_idle: assert property (@(posedge clka) disable iff (!rst_n)
    (halted || retire_valid) |-> !load_ready)
    else stop_with_error("load_ready was high while the core was busy or halted");

  task automatic next_slot();
    @(posedge clka);
    #5;
  endtask

  // arithmetic with wrap, stores to fresh pages, loads, jmp and exit
  function automatic void build_main_program();
    new_program();
    add_inst(op_num2reg, 1, 16'h0005);
    add_inst(op_num2reg, 2, 16'h1234);
    add_inst(op_reg_plus, 1, 16'h0003);
    add_inst(op_reg_minus, 1, 16'h000a);  // goes below zero
    add_inst(op_reg_plus, 2, 16'hffff);
    add_inst(op_reg2ram, 1, 16'(3 * PAGE_WORDS + 5));
    add_inst(op_reg2ram, 2, 16'(5 * PAGE_WORDS + 5));
    add_inst(op_ram2reg, 3, 16'(3 * PAGE_WORDS + 5));
    add_inst(op_ram2reg, 4, 16'd60);
    add_inst(op_jmp, 0, 16'd24);          // skips the next two
    add_inst(op_num2reg, 5, 16'hdead);
    add_inst(op_num2reg, 6, 16'hdead);
    add_inst(op_reg_plus, 4, 16'h0001);
    add_inst(op_exit, 0, 16'h0000);
    add_word(60, 16'hbeef);               // data word in page 0
  endfunction

  // fifteen free pages, so the sixteenth fresh page faults
  function automatic void build_fill_program();
    new_program();
    add_inst(op_num2reg, 1, 16'h00a5);
    for (int k = 1; k <= 16; k++) begin
      add_inst(op_reg2ram, 1, 16'(k * PAGE_WORDS + k));
    end
    add_inst(op_exit, 0, 16'h0000);
  endfunction

  task automatic run_program();
    int wait_n;
    reset_model();
    run_model(64);
    total_exp += exp_q.size();
    rst_n = 1'b0;
    repeat (10) next_slot();
    rst_n = 1'b1;
    foreach (load_addr_q[i]) begin
      wait_n = 0;
      while (!load_ready) begin
        next_slot();
        wait_n++;
        if (wait_n > 100) stop_with_error("timed out waiting for load_ready");
      end
      load_valid = 1'b1;
      load_addr  = 10'(load_addr_q[i]);
      load_data  = load_data_q[i];
      next_slot();
    end
    load_valid = 1'b0;
    start      = 1'b1;
    next_slot();
    start  = 1'b0;
    wait_n = 0;
    while (!halted) begin
      next_slot();
      wait_n++;
      if (wait_n > 5000) stop_with_error("timed out waiting for halted");
    end
    repeat (8) next_slot();  // core must stay silent once halted
    check_field("fault", 16'(exp_fault), 16'(fault));
    assert (exp_q.size() == 0)
      else stop_with_error("the core halted before all predicted retires arrived");
  endtask

  initial begin
    seed         = 32'h5d70;
    rst_n        = 1'b0;
    start        = 1'b0;
    load_valid   = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    retire_ready = 1'b0;
    seen         = 0;
    total_exp    = 0;
    build_main_program();
    run_program();
    build_fill_program();
    run_program();
    if (seen != total_exp || total_exp == 0) begin
      stop_with_error("the number of checked retires differs from the prediction");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// File: sim.f
source/cpu_pkg.sv
source/word_ram.sv
source/page_walker.sv
source/exec_core.sv
source/cpu_top.sv
tests/cpu_ref_model.sv
tests/cpu_tb.sv
